// File: files.f
+incdir+include
logic/spi_bridge_pkg.sv
logic/spi_shift_layer.sv
logic/spi_bus_master.sv
logic/reg_bank.sv
logic/spi_reg_bridge.sv
tb/spi_bridge_asserts.sv
tb/tb_spi_reg_bridge.sv

// File: include/spi_bridge_defs.svh
`ifndef SPI_BRIDGE_DEFS_SVH
`define SPI_BRIDGE_DEFS_SVH

// ------------------------------------------------------------------------
// SPI to register-bus bridge constants
// ------------------------------------------------------------------------

// First byte on MISO in every frame, sent while the command byte arrives
`define SPI_HEADER_BYTE 8'hA7

// Registers in the bank, the address wraps modulo this count
`define REG_COUNT 16

// Flops per pin synchronizer
`define SYNC_STAGES 2

// Write counter value after reset
`define STATUS_RESET 8'h00

`endif

// File: logic/reg_bank.sv
`timescale 1ns/1ps
`default_nettype none
`include "spi_bridge_defs.svh"

module reg_bank (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  cyc_i,
  input  logic                  stb_i,
  input  logic                  we_i,
  input  spi_bridge_pkg::addr_t adr_i,
  input  spi_bridge_pkg::byte_t dat_i,
  output logic                  ack_o,
  output spi_bridge_pkg::byte_t dat_o,
  output spi_bridge_pkg::byte_t status_o
);
  import spi_bridge_pkg::*;

  localparam int IDX_W = $clog2(`REG_COUNT);

  byte_t            regs [`REG_COUNT];
  logic             wait_q;         // Wait state after the strobe
  logic             w_we;           // Request captured at the strobe
  logic [IDX_W-1:0] w_idx;
  byte_t            w_dat;

  // ------------------------------------------------------------------------
  // Wait stage, ack lands two clocks after stb
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wait_q <= 1'b0;
      ack_o  <= 1'b0;
    end else begin
      wait_q <= cyc_i && stb_i;
      ack_o  <= wait_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cyc_i && stb_i) begin
      w_we  <= we_i;
      w_idx <= adr_i[IDX_W-1:0];    // Address modulo REG_COUNT
      w_dat <= dat_i;
    end
  end

  // Registers and write counter update on the ack clock
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < `REG_COUNT; i++) regs[i] <= '0;
      status_o <= `STATUS_RESET;
    end else if (wait_q && w_we) begin
      regs[w_idx] <= w_dat;
      status_o    <= status_o + 8'd1;  // Wraps at 256
    end
  end

  // Read data is valid together with ack
  always_ff @(posedge clk_i) begin
    if (wait_q) dat_o <= regs[w_idx];
  end

endmodule

`default_nettype wire

// File: logic/spi_bridge_pkg.sv
`default_nettype none

package spi_bridge_pkg;

  // Data byte, same width on the SPI link and on the bus
  typedef logic [7:0] byte_t;

  // Register address from bits 6..0 of the command byte
  typedef logic [6:0] addr_t;

  // ------------------------------------------------------------------------
  // Bus-master FSM
  // ------------------------------------------------------------------------
  typedef enum logic [2:0] {
    IDLE, // No frame
    ADDR, // Frame open, command byte pending
    BUSY, // Frame active, no bus cycle
    PUSH, // Write cycle pending
    PULL  // Read cycle pending
  } bridge_state_t;

endpackage

`default_nettype wire

// File: logic/spi_bus_master.sv
`timescale 1ns/1ps
`default_nettype none

module spi_bus_master (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  frame_i,
  input  logic                  rx_valid_i,
  input  spi_bridge_pkg::byte_t rx_data_i,
  output logic                  rx_ack_o,
  output logic                  tx_ready_o,
  output spi_bridge_pkg::byte_t tx_data_o,
  input  logic                  tx_req_i,
  output logic                  cyc_o,
  output logic                  stb_o,
  output logic                  we_o,
  output spi_bridge_pkg::addr_t adr_o,
  output spi_bridge_pkg::byte_t dat_o,
  input  logic                  ack_i,
  input  spi_bridge_pkg::byte_t dat_i,
  input  spi_bridge_pkg::byte_t status_i,
  output logic                  active_o
);
  import spi_bridge_pkg::*;

  bridge_state_t state;
  logic cmd_we;     // Write bit of the incoming command byte
  logic we_q;       // Frame mode, held until the next command
  logic wr_issue;   // Start a bus write
  logic rd_issue;   // Start a bus read
  logic st_rdy;     // Status byte ready for the tx path
  logic rd_wait;    // Read cycle outstanding

  assign cmd_we = rx_data_i[7];

  // One write per received data byte in a write frame
  assign wr_issue = (state == BUSY) && rx_valid_i && we_q;

  // One read per tx request in a read frame, the first one right
  // after the command byte
  assign rd_issue = ((state == ADDR) && rx_valid_i && !cmd_we) ||
                    ((state == BUSY) && tx_req_i && !we_q);

  // ------------------------------------------------------------------------
  // Frame FSM
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i || !frame_i) begin
      state <= IDLE;                // SSEL high ends the frame
    end else begin
      unique case (state)
        IDLE: state <= ADDR;        // Frame just opened
        ADDR: begin
          if (rx_valid_i) state <= cmd_we ? BUSY : PULL;
        end
        BUSY: begin
          if (wr_issue)      state <= PUSH;
          else if (rd_issue) state <= PULL;
        end
        PUSH, PULL: begin
          if (ack_i) state <= BUSY;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // ------------------------------------------------------------------------
  // Command decode
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) we_q <= 1'b0;
    else if ((state == ADDR) && rx_valid_i) we_q <= cmd_we;
  end

  // No auto-increment, the address holds for the whole frame
  always_ff @(posedge clk_i) begin
    if ((state == ADDR) && rx_valid_i) adr_o <= rx_data_i[6:0];
  end

  // ------------------------------------------------------------------------
  // Bus cycle generation
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cyc_o   <= 1'b0;
      stb_o   <= 1'b0;
      we_o    <= 1'b0;
      rd_wait <= 1'b0;
    end else begin
      stb_o <= wr_issue || rd_issue;   // Single-clock strobe
      if (wr_issue || rd_issue) begin
        cyc_o   <= 1'b1;
        we_o    <= wr_issue;           // Stable for the whole cycle
        rd_wait <= rd_issue;
      end else if (ack_i) begin
        cyc_o   <= 1'b0;               // Completes even after frame end
        rd_wait <= 1'b0;
      end
    end
  end

  // Write data held until the bank acknowledges
  always_ff @(posedge clk_i) begin
    if (wr_issue) dat_o <= rx_data_i;
  end

  // ------------------------------------------------------------------------
  // Handshakes with the shift layer
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rx_ack_o <= 1'b0;
      st_rdy   <= 1'b0;
    end else begin
      // Command and read-frame bytes are consumed at once, write data
      // once the bank takes it
      rx_ack_o <= (rx_valid_i && ((state == ADDR) || ((state == BUSY) && !we_q))) ||
                  ((state == PUSH) && ack_i);
      // Status answers every tx request of a write frame
      st_rdy   <= tx_req_i && (((state == ADDR) && cmd_we) ||
                               ((state == BUSY) && we_q));
    end
  end

  // Read data falls straight through with its ack
  assign tx_ready_o = st_rdy || (rd_wait && ack_i);
  assign tx_data_o  = rd_wait ? dat_i : status_i;

  assign active_o = (state != IDLE) || cyc_o;  // Busy until the bus drains

endmodule

`default_nettype wire

// File: logic/spi_reg_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module spi_reg_bridge (
  input  logic clk_i,
  input  logic rst_i,
  input  logic sck_i,
  input  logic ssel_i,
  input  logic mosi_i,
  output logic miso_o,
  output logic active_o,
  output logic overflow_o,
  output logic underrun_o
);
  import spi_bridge_pkg::*;

  // Shift layer to bus master
  logic  frame, rx_valid, rx_ack, tx_req, tx_ready;
  byte_t rx_data, tx_data;

  // Bus master to register bank
  logic  cyc, stb, we, ack;
  addr_t adr;
  byte_t wr_dat, rd_dat, status;

  // ------------------------------------------------------------------------
  // Serial front end
  // ------------------------------------------------------------------------
  spi_shift_layer u_shift (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .sck_i      (sck_i),
    .ssel_i     (ssel_i),
    .mosi_i     (mosi_i),
    .miso_o     (miso_o),
    .frame_o    (frame),
    .rx_valid_o (rx_valid),
    .rx_data_o  (rx_data),
    .rx_ack_i   (rx_ack),
    .tx_ready_i (tx_ready),
    .tx_data_i  (tx_data),
    .tx_req_o   (tx_req),
    .overflow_o (overflow_o),
    .underrun_o (underrun_o)
  );

  // Command decode and bus cycles
  spi_bus_master u_master (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .frame_i    (frame),
    .rx_valid_i (rx_valid),
    .rx_data_i  (rx_data),
    .rx_ack_o   (rx_ack),
    .tx_ready_o (tx_ready),
    .tx_data_o  (tx_data),
    .tx_req_i   (tx_req),
    .cyc_o      (cyc),
    .stb_o      (stb),
    .we_o       (we),
    .adr_o      (adr),
    .dat_o      (wr_dat),
    .ack_i      (ack),
    .dat_i      (rd_dat),
    .status_i   (status),
    .active_o   (active_o)
  );

  // Bus target
  reg_bank u_bank (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .cyc_i    (cyc),
    .stb_i    (stb),
    .we_i     (we),
    .adr_i    (adr),
    .dat_i    (wr_dat),
    .ack_o    (ack),
    .dat_o    (rd_dat),
    .status_o (status)
  );

endmodule

`default_nettype wire

// File: logic/spi_shift_layer.sv
`timescale 1ns/1ps
`default_nettype none
`include "spi_bridge_defs.svh"

module spi_shift_layer (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  sck_i,
  input  logic                  ssel_i,
  input  logic                  mosi_i,
  output logic                  miso_o,
  output logic                  frame_o,
  output logic                  rx_valid_o,
  output spi_bridge_pkg::byte_t rx_data_o,
  input  logic                  rx_ack_i,
  input  logic                  tx_ready_i,
  input  spi_bridge_pkg::byte_t tx_data_i,
  output logic                  tx_req_o,
  output logic                  overflow_o,
  output logic                  underrun_o
);
  import spi_bridge_pkg::*;

  logic [`SYNC_STAGES-1:0] sck_sync, ssel_sync, mosi_sync;
  logic       sck_s, mosi_s;        // Synchronized pins
  logic       sck_q;                // Previous SCK, for edge detect
  logic       frame_q;
  logic       frame_start;
  logic       sck_rise, sck_fall;
  logic [2:0] bit_cnt;              // Bits received in current byte
  logic [6:0] rx_shift;
  logic       rx_pend;              // Byte waiting for rx_ack_i
  byte_t      tx_shift;             // MISO shifter, MSB first
  byte_t      tx_buf;               // Next byte from the bus master
  logic       tx_have;

  // ------------------------------------------------------------------------
  // Pin synchronizers and edge detect
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sck_sync  <= '0;
      ssel_sync <= '1;              // Deselected
      mosi_sync <= '0;
      sck_q     <= 1'b0;
      frame_q   <= 1'b0;
    end else begin
      sck_sync  <= {sck_sync[`SYNC_STAGES-2:0], sck_i};
      ssel_sync <= {ssel_sync[`SYNC_STAGES-2:0], ssel_i};
      mosi_sync <= {mosi_sync[`SYNC_STAGES-2:0], mosi_i};
      sck_q     <= sck_s;
      frame_q   <= frame_o;
    end
  end

  assign sck_s       = sck_sync[`SYNC_STAGES-1];
  assign mosi_s      = mosi_sync[`SYNC_STAGES-1];
  assign frame_o     = ~ssel_sync[`SYNC_STAGES-1];  // SSEL is active low
  assign frame_start = frame_o & ~frame_q;
  assign sck_rise    = frame_o & sck_s & ~sck_q;
  assign sck_fall    = frame_o & ~sck_s & sck_q;

  // ------------------------------------------------------------------------
  // Receive side, mode 0 samples on the rising edge
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i || !frame_o) begin
      bit_cnt    <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_valid_o <= sck_rise && (bit_cnt == 3'd7);   // Byte strobe
      if (sck_rise) bit_cnt <= bit_cnt + 3'd1;       // Wraps each byte
    end
  end

  always_ff @(posedge clk_i) begin
    if (sck_rise) begin
      rx_shift <= {rx_shift[5:0], mosi_s};
      if (bit_cnt == 3'd7) rx_data_o <= {rx_shift, mosi_s};
    end
  end

  // The master is asked for the next byte as soon as one completes
  assign tx_req_o = rx_valid_o;

  // ------------------------------------------------------------------------
  // Transmit side, shifts on the falling edge
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i || !frame_o) begin
      tx_shift <= '0;               // MISO low outside a frame
      tx_have  <= 1'b0;
    end else if (frame_start) begin
      tx_shift <= `SPI_HEADER_BYTE;
      tx_have  <= 1'b0;
    end else begin
      if (sck_fall) begin
        if (bit_cnt == 3'd0) begin  // Byte boundary, load next
          tx_shift <= tx_have ? tx_buf : '0;
          tx_have  <= 1'b0;
        end else begin
          tx_shift <= {tx_shift[6:0], 1'b0};
        end
      end
      if (tx_ready_i) tx_have <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (tx_ready_i) tx_buf <= tx_data_i;
  end

  assign miso_o = tx_shift[7];

  // ------------------------------------------------------------------------
  // Sticky error flags
  // ------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rx_pend    <= 1'b0;
      overflow_o <= 1'b0;
      underrun_o <= 1'b0;
    end else begin
      if (!frame_o)        rx_pend <= 1'b0;
      else if (rx_valid_o) rx_pend <= 1'b1;
      else if (rx_ack_i)   rx_pend <= 1'b0;
      // New byte while the previous one is still unclaimed
      if (rx_valid_o && rx_pend && !rx_ack_i) overflow_o <= 1'b1;
      // Nothing to send at the first falling edge of a byte
      if (sck_fall && (bit_cnt == 3'd0) && !tx_have && !frame_start)
        underrun_o <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then look for the pass line
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f files.f \
  --top-module tb_spi_reg_bridge -o tb_sim &&
./obj_dir/tb_sim > sim.log 2>&1 ||
{ echo "Build or simulation run failed"; cat sim.log 2>/dev/null; exit 1; }
grep -q "Everything OK" sim.log && echo "PASS" ||
{ echo "FAIL"; cat sim.log; exit 1; }

// File: tb/spi_bridge_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module spi_bridge_asserts (
  input logic                          clk_i,
  input logic                          rst_i,
  input logic                          cyc_i,
  input logic                          stb_i,
  input logic                          we_i,
  input logic                          ack_i,
  input spi_bridge_pkg::bridge_state_t state_i
);
  import spi_bridge_pkg::*;

  // ------------------------------------------------------------------------
  // Bus protocol on the master side
  // ------------------------------------------------------------------------
  a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
    stb_i |-> cyc_i)
    else $error("stb asserted outside a bus cycle");

  a_cyc_until_ack: assert property (@(posedge clk_i) disable iff (rst_i)
    cyc_i && !ack_i |=> cyc_i)   // Cycle held open until its ack
    else $error("cyc dropped before ack");

  a_one_outstanding: assert property (@(posedge clk_i) disable iff (rst_i)
    cyc_i && !ack_i |=> !stb_i)
    else $error("new stb while a cycle is still open");

  a_we_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    cyc_i && !stb_i |-> $stable(we_i))
    else $error("we changed in the middle of a cycle");

  // The bank answers only into an open cycle that the FSM waits on
  a_ack_in_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
    ack_i |-> cyc_i && ((state_i == PUSH) || (state_i == PULL) || (state_i == IDLE)))
    else $error("ack outside an open bus cycle");

endmodule

bind spi_bus_master spi_bridge_asserts u_bus_asserts (
  .clk_i   (clk_i),
  .rst_i   (rst_i),
  .cyc_i   (cyc_o),
  .stb_i   (stb_o),
  .we_i    (we_o),
  .ack_i   (ack_i),
  .state_i (state)
);

`default_nettype wire

// File: tb/spi_patterns.mem
// One SPI frame per word: kind (1 write, 2 read) | data bytes | address |
// first data byte | expected read value
21050000
11053C00
2205003C
140A1000
211A0013
1323F000
230300F2
227F0000
127FFE00
240F00FF
11005500
21400055
1445FE00
22150001
210C0000
120C8000
234C0081
210A0013

// File: tb/tb_spi_reg_bridge.sv
`timescale 1ns/1ps
`default_nettype none
`include "spi_bridge_defs.svh"

module tb_spi_reg_bridge;
  import spi_bridge_pkg::*;

  localparam int PAT_COUNT    = 18;   // Words in the pattern file
  localparam int IDLE_TIMEOUT = 200;  // Clocks allowed for the bus to drain

  logic clk, rst;
  logic sck, ssel, mosi;
  logic miso, active, overflow, underrun;

  logic [31:0] patterns [PAT_COUNT];
  byte_t       model_regs [`REG_COUNT];  // Expected register contents
  byte_t       wcount;                   // Accepted writes, modulo 256

  spi_reg_bridge DUT (
    .clk_i      (clk),
    .rst_i      (rst),
    .sck_i      (sck),
    .ssel_i     (ssel),
    .mosi_i     (mosi),
    .miso_o     (miso),
    .active_o   (active),
    .overflow_o (overflow),
    .underrun_o (underrun)
  );

  always #2 clk = ~clk;               // 4 ns period

  // ------------------------------------------------------------------------
  // Error handling and typed checks
  // ------------------------------------------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_byte(input byte_t got, input byte_t exp, input string what);
    if (got !== exp)
      abort_run($sformatf("[FAIL] time %0t: %s got %02h, expected %02h",
                          $time, what, got, exp));
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp)
      abort_run($sformatf("[FAIL] time %0t: %s got %b, expected %b",
                          $time, what, got, exp));
  endtask

  // ------------------------------------------------------------------------
  // SPI master, mode 0, MSB first
  // ------------------------------------------------------------------------
  task automatic send_byte(input byte_t tx, input int half, output byte_t rx);
    for (int i = 7; i >= 0; i--) begin
      @(posedge clk);
      mosi <= tx[i];                  // SCK is low here
      repeat (half - 1) @(posedge clk);
      @(negedge clk);
      rx[i] = miso;                   // Slave bit settled during the low phase
      @(posedge clk);
      sck <= 1'b1;
      repeat (half) @(posedge clk);
      sck <= 1'b0;
    end
  endtask

  // Frame over, the bus has to go quiet within the timeout
  task automatic wait_bus_idle();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (active && (cycles < IDLE_TIMEOUT)) begin
      @(negedge clk);
      cycles++;
    end
    if (active)
      abort_run("Timeout: active_o stayed high after SSEL was released");
  endtask

  // One frame from one pattern word, checked against the model
  task automatic run_frame(input logic [31:0] pat);
    logic [3:0] kind;
    logic       is_write, is_read;
    int         n, idx, half;
    byte_t      addr_b, first_d, exp_rd, cmd, rx, tx_b, exp_b, count0;
    kind     = pat[31:28];
    is_write = (kind == 4'h1);
    is_read  = (kind == 4'h2);
    n        = int'(pat[27:24]);
    addr_b   = pat[23:16];
    first_d  = pat[15:8];
    exp_rd   = pat[7:0];
    if (!(is_write || is_read) || (n < 1) || (n > 4))
      abort_run("Pattern file holds a word with an unknown frame kind or byte count");
    idx    = int'(addr_b) % `REG_COUNT;   // Bank aliases the upper addresses
    half   = 8 + int'($urandom % 5);
    cmd    = {is_write, addr_b[6:0]};
    count0 = wcount;

    @(posedge clk);
    ssel <= 1'b0;
    repeat (half) @(posedge clk);     // Header has time to load
    send_byte(cmd, half, rx);
    check_byte(rx, `SPI_HEADER_BYTE, "header byte");
    @(negedge clk);
    check_flag(active, 1'b1, "active during frame");

    for (int j = 1; j <= n; j++) begin
      if (is_write) begin
        tx_b = first_d + byte_t'(j - 1);
        send_byte(tx_b, half, rx);
        // Status trails by one byte, the write of byte j-1 is not counted yet
        exp_b = (j == 1) ? count0 : count0 + byte_t'(j - 2);
        check_byte(rx, exp_b, "write status byte");
      end else begin
        send_byte(8'h00, half, rx);
        check_byte(rx, model_regs[idx], "read data byte");
      end
    end

    if (is_write) begin
      model_regs[idx] = first_d + byte_t'(n - 1);  // Last byte wins
      wcount          = wcount + byte_t'(n);
    end else begin
      check_byte(rx, exp_rd, "read value against pattern file");
    end

    repeat (half) @(posedge clk);
    ssel <= 1'b1;
    wait_bus_idle();
    check_flag(overflow, 1'b0, "overflow flag");
    check_flag(underrun, 1'b0, "underrun flag");
  endtask

  // ------------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------------
  initial begin
    int gap;
    clk  = 1'b0;
    rst  = 1'b1;
    sck  = 1'b0;
    ssel = 1'b1;                      // Deselected
    mosi = 1'b0;
    void'($urandom(32'h7848afb9));
    for (int k = 0; k < `REG_COUNT; k++) model_regs[k] = '0;
    wcount = `STATUS_RESET;
    $readmemh("tb/spi_patterns.mem", patterns);

    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_flag(miso, 1'b0, "MISO after reset");
    check_flag(active, 1'b0, "active after reset");
    check_flag(overflow, 1'b0, "overflow after reset");
    check_flag(underrun, 1'b0, "underrun after reset");

    for (int p = 0; p < PAT_COUNT; p++) begin
      run_frame(patterns[p]);
      gap = 4 + int'($urandom % 16);  // Random idle time between frames
      repeat (gap) @(posedge clk);
    end

    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire
